//--- fetch_addr_counter.sv
////////////////////////////////////////////////////////////
// fetch address counter
// next bus address, loaded on redirect and stepped on grant,
// plus the address of the request still in flight
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module fetch_addr_counter (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                load_i,
  input  if_stage_pkg::addr_t load_addr_i,
  input  logic                step_i,
  output if_stage_pkg::addr_t fetch_addr_o,
  output if_stage_pkg::addr_t req_addr_o
);

  import if_stage_pkg::*;

  addr_t fetch_addr_q;
  addr_t req_addr_q;

  // redirect wins over a grant in the same cycle
  // a word granted alongside a redirect is dropped by the fsm
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_addr_q <= '0;
    end else if (load_i) begin
      // only word fetches, force alignment
      fetch_addr_q <= {load_addr_i[31:2], 2'b00};
    end else if (step_i) begin
      fetch_addr_q <= fetch_addr_q + INSTR_BYTES;
    end
  end

  // tag for the response, taken from the address on the bus
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_addr_q <= '0;
    end else if (step_i) begin
      req_addr_q <= fetch_addr_q;
    end
  end

  assign fetch_addr_o = fetch_addr_q;
  assign req_addr_o   = req_addr_q;

endmodule

//--- fetch_fsm.sv
////////////////////////////////////////////////////////////
// fetch fsm
// issues one bus request at a time and throws away a
// response that a redirect has made stale
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module fetch_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic req_i,
  input  logic pc_set_i,
  input  logic hold_busy_i,
  input  logic instr_gnt_i,
  input  logic instr_rvalid_i,
  output logic instr_req_o,
  output logic rsp_keep_o,
  output logic busy_o
);

  import if_stage_pkg::*;

  fetch_state_e state_q;
  fetch_state_e state_d;
  logic         granted;

  // request only while the core wants fetching and the
  // holding entry has room for the answer
  assign instr_req_o = (state_q == FETCH_REQ) & req_i & ~hold_busy_i;
  assign granted     = instr_req_o & instr_gnt_i;

  ////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      FETCH_IDLE: begin
        // nothing to fetch before the first redirect
        if (pc_set_i) begin
          state_d = FETCH_REQ;
        end
      end
      FETCH_REQ: begin
        if (granted) begin
          // granted word is stale if a redirect comes with it
          state_d = pc_set_i ? FETCH_DISCARD : FETCH_WAIT;
        end
      end
      FETCH_WAIT: begin
        if (instr_rvalid_i) begin
          state_d = FETCH_REQ;
        end else if (pc_set_i) begin
          // response still owed, eat it first
          state_d = FETCH_DISCARD;
        end
      end
      FETCH_DISCARD: begin
        // new address is already loaded, just drain
        if (instr_rvalid_i) begin
          state_d = FETCH_REQ;
        end
      end
      default: state_d = FETCH_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= FETCH_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // keep only answers to the current stream
  // a redirect in the same cycle squashes the word
  assign rsp_keep_o = (state_q == FETCH_WAIT) & instr_rvalid_i & ~pc_set_i;
  assign busy_o     = (state_q != FETCH_IDLE);

endmodule

//--- if_id_pipe.sv
////////////////////////////////////////////////////////////
// if-id pipeline
// holding entry for the returned word, the ID registers
// and the sequential pc check
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module if_id_pipe (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 rsp_keep_i,
  input  if_stage_pkg::instr_t rsp_rdata_i,
  input  logic                 rsp_err_i,
  input  if_stage_pkg::addr_t  rsp_addr_i,
  input  logic                 pc_set_i,
  input  logic                 id_in_ready_i,
  input  logic                 instr_valid_clear_i,
  output logic                 hold_busy_o,
  output if_stage_pkg::addr_t  pc_if_o,
  output if_stage_pkg::if_id_t id_o,
  output logic                 instr_valid_id_o,
  output logic                 instr_new_id_o,
  output logic                 pc_mismatch_alert_o
);

  import if_stage_pkg::*;

  if_id_t hold_q;
  logic   hold_valid_q;
  if_id_t id_q;
  logic   valid_id_q;
  logic   new_id_q;
  logic   seq_q;
  logic   hold_leave;

  // word moves to ID unless ID stalls or a redirect squashes it
  assign hold_leave  = hold_valid_q & id_in_ready_i & ~pc_set_i;
  assign hold_busy_o = hold_valid_q & ~hold_leave;

  ////////////////////////////////////////////////////////////
  // holding entry
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_valid_q <= 1'b0;
    end else if (pc_set_i) begin
      hold_valid_q <= 1'b0;
    end else if (rsp_keep_i) begin
      hold_valid_q <= 1'b1;
    end else if (hold_leave) begin
      hold_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rsp_keep_i) begin
      hold_q.instr     <= rsp_rdata_i;
      hold_q.pc        <= rsp_addr_i;
      hold_q.fetch_err <= rsp_err_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // ID registers
  ////////////////////////////////////////////////////////////

  // valid sticks until the controller clears it
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_id_q <= 1'b0;
      new_id_q   <= 1'b0;
      seq_q      <= 1'b0;
    end else begin
      valid_id_q <= hold_leave | (valid_id_q & ~instr_valid_clear_i);
      new_id_q   <= hold_leave;
      // any redirect breaks the sequential run
      seq_q      <= (seq_q | hold_leave) & ~pc_set_i;
    end
  end

  // frozen while ID stalls
  always_ff @(posedge clk_i) begin
    if (hold_leave) begin
      id_q <= hold_q;
    end
  end

  assign pc_if_o          = hold_q.pc;
  assign id_o             = id_q;
  assign instr_valid_id_o = valid_id_q;
  assign instr_new_id_o   = new_id_q;

  // held word must sit one word above the one in ID
  assign pc_mismatch_alert_o = seq_q & hold_valid_q & (hold_q.pc != id_q.pc + INSTR_BYTES);

endmodule

//--- if_stage.f
if_stage_pkg.sv
pc_target_mux.sv
fetch_addr_counter.sv
fetch_fsm.sv
if_id_pipe.sv
if_stage_top.sv
if_stage_assert.sv
tb_if_stage.sv

//--- if_stage_assert.sv
////////////////////////////////////////////////////////////
// fetch stage assertions
// bus request rules and IF-ID pipeline invariants
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module if_stage_assert (
  input logic                clk_i,
  input logic                rst_ni,
  input logic                pc_set_i,
  input logic                instr_req_o,
  input if_stage_pkg::addr_t instr_addr_o,
  input logic                instr_gnt_i,
  input logic                instr_new_id_o,
  input logic                pc_mismatch_alert_o
);

  int fail_cnt = 0;

  // request waits for its grant with a steady address
  req_held_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o && !instr_gnt_i && !pc_set_i |=> instr_req_o && $stable(instr_addr_o))
  else begin
    $error("fetch request dropped or moved before its grant");
    fail_cnt++;
  end

  // single outstanding request
  one_out_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o && instr_gnt_i |=> !instr_req_o)
  else begin
    $error("new request issued right after a grant");
    fail_cnt++;
  end

  // a redirect squashes any word on its way into ID
  squash_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_id_o |-> !$past(pc_set_i) && !$past(pc_set_i, 2))
  else begin
    $error("word entered ID right after a redirect");
    fail_cnt++;
  end

  // fetch stream stays sequential in normal flow
  no_alert_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !pc_mismatch_alert_o)
  else begin
    $error("sequential pc alert raised");
    fail_cnt++;
  end

endmodule

bind if_stage_top if_stage_assert u_if_stage_assert (
  .clk_i               (clk_i),
  .rst_ni              (rst_ni),
  .pc_set_i            (pc_set_i),
  .instr_req_o         (instr_req_o),
  .instr_addr_o        (instr_addr_o),
  .instr_gnt_i         (instr_gnt_i),
  .instr_new_id_o      (instr_new_id_o),
  .pc_mismatch_alert_o (pc_mismatch_alert_o)
);

//--- if_stage_pkg.sv
////////////////////////////////////////////////////////////
// instruction fetch stage package
// shared widths, selector encodings, bundles and fixed
// addresses for the fetch stage
////////////////////////////////////////////////////////////

package if_stage_pkg;

  // byte address and instruction word
  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_t;

  // interrupt line number used for vectoring
  typedef logic [4:0]  irq_id_t;

  // redirect source, driven by the controller with pc_set
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // exception vector source
  typedef enum logic [2:0] {
    EXC_PC_EXC     = 3'd0,
    EXC_PC_IRQ     = 3'd1,
    EXC_PC_IRQ_X   = 3'd2,
    EXC_PC_DBD     = 3'd3,
    EXC_PC_DBG_EXC = 3'd4
  } exc_pc_sel_e;

  // bus side fetch sequencer
  typedef enum logic [1:0] {
    FETCH_IDLE    = 2'd0,
    FETCH_REQ     = 2'd1,
    FETCH_WAIT    = 2'd2,
    FETCH_DISCARD = 2'd3
  } fetch_state_e;

  // return and trap addresses held in the CSR file
  typedef struct packed {
    addr_t mepc;
    addr_t depc;
    addr_t mtvec;
    addr_t mtvecx;
  } csr_pc_t;

  // word sitting in the holding entry or in ID
  typedef struct packed {
    instr_t instr;
    addr_t  pc;
    logic   fetch_err;
  } if_id_t;

  // boot lands 0x80 above the aligned boot base
  localparam logic [7:0]  BOOT_OFFSET    = 8'h80;
  // low bits dropped from boot and trap vector bases
  localparam int unsigned VEC_ALIGN_BITS = 8;
  // debug module entry points
  localparam addr_t       DM_HALT_ADDR   = 32'h1A110800;
  localparam addr_t       DM_EXC_ADDR    = 32'h1A110808;
  // uncompressed only, so the pc always steps by a word
  localparam addr_t       INSTR_BYTES    = 32'd4;

endpackage

//--- if_stage_top.sv
////////////////////////////////////////////////////////////
// instruction fetch stage
// redirect selection, bus fetch and IF-ID handoff
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module if_stage_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      req_i,
  input  if_stage_pkg::addr_t       boot_addr_i,
  input  logic                      pc_set_i,
  input  if_stage_pkg::pc_sel_e     pc_mux_i,
  input  if_stage_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  if_stage_pkg::irq_id_t     exc_irq_i,
  input  if_stage_pkg::addr_t       branch_target_i,
  input  if_stage_pkg::csr_pc_t     csr_i,
  input  logic                      id_in_ready_i,
  input  logic                      instr_valid_clear_i,
  // instruction bus
  output logic                      instr_req_o,
  output if_stage_pkg::addr_t       instr_addr_o,
  input  logic                      instr_gnt_i,
  input  logic                      instr_rvalid_i,
  input  if_stage_pkg::instr_t      instr_rdata_i,
  input  logic                      instr_err_i,
  // towards ID and the CSR file
  output if_stage_pkg::if_id_t      id_o,
  output logic                      instr_valid_id_o,
  output logic                      instr_new_id_o,
  output if_stage_pkg::addr_t       pc_if_o,
  output logic                      csr_mtvec_init_o,
  output logic                      pc_mismatch_alert_o,
  output logic                      if_busy_o
);

  import if_stage_pkg::*;

  addr_t redirect_addr;
  addr_t req_addr;
  logic  fetch_step;
  logic  rsp_keep;
  logic  hold_busy;

  // address advances on every accepted request
  assign fetch_step = instr_req_o & instr_gnt_i;

  // CSR file loads mtvec from the boot base
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

  pc_target_mux u_pc_target_mux (
    .pc_mux_i        (pc_mux_i),
    .exc_pc_mux_i    (exc_pc_mux_i),
    .exc_irq_i       (exc_irq_i),
    .boot_addr_i     (boot_addr_i),
    .branch_target_i (branch_target_i),
    .csr_i           (csr_i),
    .redirect_addr_o (redirect_addr)
  );

  fetch_addr_counter u_fetch_addr_counter (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .load_i       (pc_set_i),
    .load_addr_i  (redirect_addr),
    .step_i       (fetch_step),
    .fetch_addr_o (instr_addr_o),
    .req_addr_o   (req_addr)
  );

  fetch_fsm u_fetch_fsm (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .pc_set_i       (pc_set_i),
    .hold_busy_i    (hold_busy),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_req_o    (instr_req_o),
    .rsp_keep_o     (rsp_keep),
    .busy_o         (if_busy_o)
  );

  if_id_pipe u_if_id_pipe (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .rsp_keep_i          (rsp_keep),
    .rsp_rdata_i         (instr_rdata_i),
    .rsp_err_i           (instr_err_i),
    .rsp_addr_i          (req_addr),
    .pc_set_i            (pc_set_i),
    .id_in_ready_i       (id_in_ready_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .hold_busy_o         (hold_busy),
    .pc_if_o             (pc_if_o),
    .id_o                (id_o),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .pc_mismatch_alert_o (pc_mismatch_alert_o)
  );

endmodule

//--- pc_target_mux.sv
////////////////////////////////////////////////////////////
// pc target mux
// builds the trap vector and picks the redirect address
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module pc_target_mux (
  input  if_stage_pkg::pc_sel_e     pc_mux_i,
  input  if_stage_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  if_stage_pkg::irq_id_t     exc_irq_i,
  input  if_stage_pkg::addr_t       boot_addr_i,
  input  if_stage_pkg::addr_t       branch_target_i,
  input  if_stage_pkg::csr_pc_t     csr_i,
  output if_stage_pkg::addr_t       redirect_addr_o
);

  import if_stage_pkg::*;

  addr_t mtvec_base;
  addr_t mtvecx_base;
  addr_t irq_offset;
  addr_t boot_target;
  addr_t exc_pc;

  // vector tables and boot region are aligned to 256 bytes
  assign mtvec_base  = {csr_i.mtvec[31:VEC_ALIGN_BITS], {VEC_ALIGN_BITS{1'b0}}};
  assign mtvecx_base = {csr_i.mtvecx[31:VEC_ALIGN_BITS], {VEC_ALIGN_BITS{1'b0}}};
  assign boot_target = {boot_addr_i[31:VEC_ALIGN_BITS], {VEC_ALIGN_BITS{1'b0}}} +
                       addr_t'(BOOT_OFFSET);

  // one table entry per interrupt line, each a single jump
  assign irq_offset = addr_t'(exc_irq_i) << 2;

  ////////////////////////////////////////////////////////////
  // trap vector
  ////////////////////////////////////////////////////////////

  always_comb begin
    unique case (exc_pc_mux_i)
      EXC_PC_EXC:     exc_pc = mtvec_base;
      EXC_PC_IRQ:     exc_pc = mtvec_base + irq_offset;
      // extra interrupt table lives behind mtvecx
      EXC_PC_IRQ_X:   exc_pc = mtvecx_base + irq_offset;
      EXC_PC_DBD:     exc_pc = DM_HALT_ADDR;
      EXC_PC_DBG_EXC: exc_pc = DM_EXC_ADDR;
      default:        exc_pc = mtvec_base;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // redirect target
  ////////////////////////////////////////////////////////////

  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT: redirect_addr_o = boot_target;
      PC_JUMP: redirect_addr_o = branch_target_i;
      PC_EXC:  redirect_addr_o = exc_pc;
      // return from trap
      PC_ERET: redirect_addr_o = csr_i.mepc;
      // return from debug mode
      PC_DRET: redirect_addr_o = csr_i.depc;
      default: redirect_addr_o = boot_target;
    endcase
  end

endmodule

//--- run.sh
#!/usr/bin/env bash
# build the fetch stage testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f if_stage.f --top-module tb_if_stage \
  --Mdir obj_dir -o tb_if_stage
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_if_stage +verilator+error+limit+100 > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -q "All tests passed!" sim.log; then
  exit 0
fi
echo "pass line not found in sim.log"
exit 1

//--- tb_if_stage.sv
////////////////////////////////////////////////////////////
// fetch stage testbench
// directed tests against a randomized instruction bus model
////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_if_stage;

  import if_stage_pkg::*;

  localparam int WAIT_LIMIT = 200;

  logic        clk_i;
  logic        rst_ni;
  logic        req_i;
  addr_t       boot_addr_i;
  logic        pc_set_i;
  pc_sel_e     pc_mux_i;
  exc_pc_sel_e exc_pc_mux_i;
  irq_id_t     exc_irq_i;
  addr_t       branch_target_i;
  csr_pc_t     csr_i;
  logic        id_in_ready_i;
  logic        instr_valid_clear_i;
  logic        instr_req_o;
  addr_t       instr_addr_o;
  logic        instr_gnt_i;
  logic        instr_rvalid_i;
  instr_t      instr_rdata_i;
  logic        instr_err_i;
  if_id_t      id_o;
  logic        instr_valid_id_o;
  logic        instr_new_id_o;
  addr_t       pc_if_o;
  logic        csr_mtvec_init_o;
  logic        pc_mismatch_alert_o;
  logic        if_busy_o;

  // bus model state
  addr_t       rsp_addr;
  logic        rsp_pending = 1'b0;
  int          rsp_cnt = 0;
  int          gnt_delay = 0;
  int          wait_cnt = 0;
  addr_t       err_addr = 32'hffff_ffff;

  logic [31:0] lfsr = 32'hec48_cf1f;
  string       cur_test = "reset";
  // IF pc seen in the cycle the last word left for ID
  addr_t       leave_pc_if;

  if_stage_top uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  // galois form, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
  endfunction

  // one lfsr step per bit taken
  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  // trap vector as the CSR rules define it
  function automatic addr_t vector_addr(input exc_pc_sel_e sel, input irq_id_t irq);
    addr_t irq_off;
    irq_off = {25'd0, irq, 2'b00};
    case (sel)
      EXC_PC_EXC:   return {csr_i.mtvec[31:8], 8'h00};
      EXC_PC_IRQ:   return {csr_i.mtvec[31:8], 8'h00} + irq_off;
      EXC_PC_IRQ_X: return {csr_i.mtvecx[31:8], 8'h00} + irq_off;
      EXC_PC_DBD:   return 32'h1A11_0800;
      default:      return 32'h1A11_0808;
    endcase
  endfunction

  task automatic abort_run();
    $display("Test failures found");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_addr(input string what, input addr_t exp, input addr_t act);
    if (exp !== act) begin
      $display("Mismatch in %s, %s: expected %h, actual %h", cur_test, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_instr(input string what, input instr_t exp, input instr_t act);
    if (exp !== act) begin
      $display("Mismatch in %s, %s: expected %h, actual %h", cur_test, what, exp, act);
      abort_run();
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Mismatch in %s, %s: expected %b, actual %b", cur_test, what, exp, act);
      abort_run();
    end
  endtask

  // memory answers every address with its inverse
  // the IF pc must have shown the same word before it left
  task automatic check_word(input if_id_t w, input addr_t exp_pc, input logic exp_err);
    check_addr("pc", exp_pc, w.pc);
    check_addr("pc_if", exp_pc, leave_pc_if);
    check_instr("instr", ~exp_pc, w.instr);
    check_bit("fetch_err", exp_err, w.fetch_err);
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  // one cycle redirect pulse, mtvec init must follow boot only
  task automatic redirect(input pc_sel_e sel);
    pc_mux_i = sel;
    pc_set_i = 1'b1;
    @(negedge clk_i);
    check_bit("csr_mtvec_init", sel == PC_BOOT, csr_mtvec_init_o);
    next_cycle();
    pc_set_i = 1'b0;
  endtask

  task automatic next_id_word(output if_id_t w, input logic rand_ready);
    int    n;
    logic  found;
    addr_t prev_pc_if;
    found      = 1'b0;
    prev_pc_if = pc_if_o;
    for (n = 0; n < WAIT_LIMIT && !found; n++) begin
      @(negedge clk_i);
      check_bit("pc alert", 1'b0, pc_mismatch_alert_o);
      if (instr_new_id_o) begin
        w           = id_o;
        leave_pc_if = prev_pc_if;
        found       = 1'b1;
      end
      // holding entry pc, one cycle ahead of the new pulse
      prev_pc_if = pc_if_o;
      next_cycle();
      if (rand_ready) begin
        id_in_ready_i = (take_bits(1) != 0);
      end
    end
    if (!found) begin
      $display("%s: no new word reached ID in %0d cycles", cur_test, WAIT_LIMIT);
      abort_run();
    end
  endtask

  // assertion failures end the run at once
  always @(negedge clk_i) begin
    if (uut.u_if_stage_assert.fail_cnt != 0) begin
      abort_run();
    end
  end

  ////////////////////////////////////////////////////////////
  // bus memory model
  ////////////////////////////////////////////////////////////

  // sample at the falling edge, drive just after the rising edge
  initial begin
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    instr_err_i    = 1'b0;
    forever begin
      @(negedge clk_i);
      if (instr_req_o && instr_gnt_i) begin
        rsp_addr    = instr_addr_o;
        rsp_cnt     = 1 + take_bits(2) % 3;
        gnt_delay   = take_bits(2) % 3;
        wait_cnt    = 0;
        rsp_pending = 1'b1;
      end else if (instr_req_o) begin
        wait_cnt++;
      end
      next_cycle();
      instr_rvalid_i = 1'b0;
      instr_rdata_i  = '0;
      instr_err_i    = 1'b0;
      if (rsp_pending) begin
        if (rsp_cnt == 1) begin
          instr_rvalid_i = 1'b1;
          instr_rdata_i  = ~rsp_addr;
          instr_err_i    = (rsp_addr == err_addr);
          rsp_pending    = 1'b0;
        end else begin
          rsp_cnt--;
        end
      end
      // grant pre-armed once the drawn delay has passed
      instr_gnt_i = !rsp_pending && (wait_cnt >= gnt_delay);
    end
  end

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  task automatic test_boot();
    if_id_t w;
    cur_test = "test_boot";
    @(negedge clk_i);
    check_bit("req after reset", 1'b0, instr_req_o);
    check_bit("valid after reset", 1'b0, instr_valid_id_o);
    check_bit("new after reset", 1'b0, instr_new_id_o);
    check_bit("alert after reset", 1'b0, pc_mismatch_alert_o);
    check_bit("busy after reset", 1'b0, if_busy_o);
    next_cycle();
    redirect(PC_BOOT);
    @(negedge clk_i);
    check_bit("busy after boot", 1'b1, if_busy_o);
    next_id_word(w, 1'b0);
    check_word(w, {boot_addr_i[31:8], 8'h00} + 32'h80, 1'b0);
  endtask

  task automatic test_stream();
    if_id_t w;
    cur_test = "test_stream";
    branch_target_i = 32'h0000_2000;
    redirect(PC_JUMP);
    for (int i = 0; i < 16; i++) begin
      next_id_word(w, 1'b1);
      check_word(w, 32'h0000_2000 + addr_t'(4 * i), 1'b0);
    end
    id_in_ready_i = 1'b1;
  endtask

  task automatic test_exc_vectors();
    exc_pc_sel_e sels[5] = '{EXC_PC_EXC, EXC_PC_IRQ, EXC_PC_IRQ_X, EXC_PC_DBD, EXC_PC_DBG_EXC};
    irq_id_t     irqs[2] = '{5'd3, 5'd17};
    if_id_t      w;
    cur_test = "test_exc_vectors";
    for (int s = 0; s < 5; s++) begin
      for (int k = 0; k < 2; k++) begin
        exc_pc_mux_i = sels[s];
        exc_irq_i    = irqs[k];
        redirect(PC_EXC);
        next_id_word(w, 1'b0);
        check_word(w, vector_addr(sels[s], irqs[k]), 1'b0);
      end
    end
  endtask

  task automatic test_redirect_outstanding();
    if_id_t w;
    addr_t  stale;
    logic   owed;
    cur_test = "test_redirect_outstanding";
    branch_target_i = 32'h0000_3000;
    redirect(PC_JUMP);
    next_id_word(w, 1'b0);
    check_word(w, 32'h0000_3000, 1'b0);
    // find a granted fetch whose rvalid is still at least a cycle away
    owed = 1'b0;
    for (int n = 0; n < WAIT_LIMIT && !owed; n++) begin
      @(negedge clk_i);
      #1;
      owed = rsp_pending && (rsp_cnt > 1);
    end
    if (!owed) begin
      $display("%s: no outstanding fetch seen in %0d cycles", cur_test, WAIT_LIMIT);
      abort_run();
    end
    stale = rsp_addr;
    next_cycle();
    branch_target_i = 32'h0000_5004;
    redirect(PC_JUMP);
    for (int i = 0; i < 3; i++) begin
      next_id_word(w, 1'b0);
      check_bit("stale word", 1'b0, w.pc == stale);
      check_word(w, 32'h0000_5004 + addr_t'(4 * i), 1'b0);
    end
  endtask

  task automatic test_bus_error();
    if_id_t w;
    cur_test = "test_bus_error";
    err_addr        = 32'h0000_7008;
    branch_target_i = 32'h0000_7008;
    redirect(PC_JUMP);
    next_id_word(w, 1'b0);
    check_word(w, 32'h0000_7008, 1'b1);
    // clear while ID stalls, nothing may refill it
    id_in_ready_i       = 1'b0;
    instr_valid_clear_i = 1'b1;
    @(negedge clk_i);
    check_bit("valid before clear", 1'b1, instr_valid_id_o);
    next_cycle();
    instr_valid_clear_i = 1'b0;
    @(negedge clk_i);
    check_bit("valid after clear", 1'b0, instr_valid_id_o);
    next_cycle();
    @(negedge clk_i);
    check_bit("valid while stalled", 1'b0, instr_valid_id_o);
    next_cycle();
    id_in_ready_i = 1'b1;
    err_addr      = 32'hffff_ffff;
  endtask

  initial begin
    rst_ni              = 1'b0;
    req_i               = 1'b1;
    boot_addr_i         = 32'h0000_1234;
    pc_set_i            = 1'b0;
    pc_mux_i            = PC_BOOT;
    exc_pc_mux_i        = EXC_PC_EXC;
    exc_irq_i           = '0;
    branch_target_i     = '0;
    csr_i.mepc          = 32'h0000_0a00;
    csr_i.depc          = 32'h0000_0b00;
    csr_i.mtvec         = 32'h0000_4123;
    csr_i.mtvecx        = 32'h0000_6a55;
    id_in_ready_i       = 1'b1;
    instr_valid_clear_i = 1'b0;
    repeat (16) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    test_boot();
    test_stream();
    test_exc_vectors();
    test_redirect_outstanding();
    test_bus_error();

    if (uut.u_if_stage_assert.fail_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule
